// ==== sim/fmModCases.txt ====
# W name addr byteEn data | R name addr expected | C name cycles
# All numbers are hex
R rst0Freq 000 00000000
R rst0Dev 001 00000000
R rst0Br 002 00000000
R rst0Cic 003 00000000
R rst1Freq 100 00000000
R rst1Dev 101 00000000
R rst1Br 102 00000000
R rst1Cic 103 00000000
R rst2Freq 200 00000000
R rst2Dev 201 00000000
R rst2Br 202 00000000
R rst2Cic 203 00000000
R rst3Freq 300 00000000
R rst3Dev 301 00000000
R rst3Br 302 00000000
R rst3Cic 303 00000000
C idle 4
W freqAll 000 f 12345678
W freqLane2 000 4 aabbccdd
R freqRd 000 12bb5678
W devUpper 001 4 ffffffff
R devRd 001 00030000
W divLow 002 3 00000005
W clkSel 002 8 ffffffff
R bitrateRd 002 80000005
W cicSet 003 1 000000e3
R cicRd 003 00000003
W badChan 500 f ffffffff
W badOff 007 f ffffffff
R badChanRd 500 00000000
R keepFreq 000 12bb5678
R keepDev 001 00030000
W c1Freq 100 f 00400000
W c1Dev 101 7 00010000
W c2Freq 200 f 00123456
W c2Dev 201 3 00001000
W c2Div 202 3 00000003
W c2Shift 203 1 00000001
W c3Freq 300 f 01000000
W c3Div 302 1 00000002
W c3Shift 303 1 00000002
C runMix 40
W c0Sat 000 f 10000000
W c1Sat 100 f 10000000
W c2Sat 200 f 10000000
W c3Sat 300 f 10000000
W c0Shift0 003 1 00000000
W c2Shift0 203 1 00000000
W c3Shift0 303 1 00000000
C runSat 40

// ==== sim/fmModTb.sv ====
`default_nettype none

module fmModTb
    import fmDspPkg::*;
();

    timeunit 1ns;
    timeprecision 10ps;

    localparam int numCh = 4;

    logic             clk;
    logic             rstN;
    logic             cs;
    logic             wrEn;
    logic [3:0]       byteEn;
    logic [11:0]      addr;
    logic [31:0]      dataIn;
    logic [31:0]      dataOut;
    logic [numCh-1:0] symbolBits;
    logic [numCh-1:0] bitReqs;
    sampleT           sampleOut;

    // Reference model of registers, channels and combiner
    chanCfgT          mCfg [numCh];
    logic [31:0]      mPhase [numCh];
    logic [15:0]      mDiv [numCh];
    logic             mTog [numCh];
    logic             mSym [numCh];
    logic [numCh-1:0] mReq;
    sampleT           mSamp [numCh];
    sampleT           mOut;

    string       qKind [$];
    string       qName [$];
    logic [31:0] qA [$];
    logic [31:0] qB [$];
    logic [31:0] qC [$];
    string       curName;
    int          errCount = 0;
    int          failCount = 0;
    int          limit = 1000000;
    int          cycles = 0;

    fmModTop #(
        .numChannels(numCh)
    ) i_fmModTop (
        .clk,
        .rstN,
        .cs,
        .wrEn,
        .byteEn,
        .addr,
        .dataIn,
        .dataOut,
        .symbolBits,
        .bitReqs,
        .sampleOut
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run did not finish within %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic loadCases();
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        limit = 100;
        fd = $fopen("sim/fmModCases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open sim/fmModCases.txt");
            failCount++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h %h", kind, name, a, b, c);
                if (n >= 3 && kind != "#") begin
                    limit += (kind == "C") ? int'(a) : 1;
                    if (kind == "W" || kind == "R" || kind == "C") begin
                        qKind.push_back(kind);
                        qName.push_back(name);
                        qA.push_back(a);
                        qB.push_back(b);
                        qC.push_back(c);
                    end else begin
                        $display("ERROR: unknown command %s in cases file", kind);
                        failCount++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Register write with byte lanes
    task automatic writeModel();
        int ch;
        ch = int'(addr[11:8]);
        if (cs && wrEn && ch < numCh) begin
            case (addr[3:0])
                4'd0: begin
                    for (int b = 0; b < 4; b++) begin
                        if (byteEn[b]) mCfg[ch].carrierFreq[8*b +: 8] = dataIn[8*b +: 8];
                    end
                end
                4'd1: begin
                    if (byteEn[0]) mCfg[ch].deviation[7:0] = dataIn[7:0];
                    if (byteEn[1]) mCfg[ch].deviation[15:8] = dataIn[15:8];
                    if (byteEn[2]) mCfg[ch].deviation[17:16] = dataIn[17:16];
                end
                4'd2: begin
                    if (byteEn[0]) mCfg[ch].bitrateDiv[7:0] = dataIn[7:0];
                    if (byteEn[1]) mCfg[ch].bitrateDiv[15:8] = dataIn[15:8];
                    if (byteEn[3]) mCfg[ch].modClkSel = dataIn[31];
                end
                4'd3: begin
                    if (byteEn[0]) mCfg[ch].cicShift = dataIn[4:0];
                end
                default: ;
            endcase
        end
    endtask

    // One clock edge of the model, always from the previous state
    task automatic modelStep();
        int          sum;
        logic        en;
        sampleT      hi;
        logic [31:0] dev;
        if (!rstN) begin
            for (int i = 0; i < numCh; i++) begin
                mCfg[i] = '0;
                mPhase[i] = '0;
                mDiv[i] = '0;
                mTog[i] = 1'b0;
                mSym[i] = 1'b0;
                mSamp[i] = '0;
            end
            mReq = '0;
            mOut = '0;
        end else begin
            sum = 0;
            for (int i = 0; i < numCh; i++) begin
                sum += int'(mSamp[i]);
            end
            if (sum > 32767) sum = 32767;
            else if (sum < -32768) sum = -32768;
            mOut = sampleT'(sum);
            for (int i = 0; i < numCh; i++) begin
                hi = mPhase[i][31:16];
                mSamp[i] = hi >>> mCfg[i].cicShift;
                en = !mCfg[i].modClkSel || mTog[i];
                mTog[i] = mCfg[i].modClkSel && !mTog[i];
                mReq[i] = 1'b0;
                dev = {{14{mCfg[i].deviation[17]}}, mCfg[i].deviation};
                if (en) begin
                    mPhase[i] += mSym[i] ? mCfg[i].carrierFreq + dev : mCfg[i].carrierFreq - dev;
                    if (mDiv[i] >= mCfg[i].bitrateDiv) begin
                        mDiv[i] = '0;
                        mReq[i] = 1'b1;
                        mSym[i] = symbolBits[i];
                    end else begin
                        mDiv[i]++;
                    end
                end
            end
            writeModel();
        end
    endtask

    task automatic driveBus(input logic c, input logic w, input logic [31:0] a,
                            input logic [31:0] be, input logic [31:0] d);
        cs <= c;
        wrEn <= w;
        byteEn <= be[3:0];
        addr <= a[11:0];
        dataIn <= d;
        symbolBits <= numCh'($urandom);
    endtask

    // Check at the falling edge, then advance DUT and model together
    task automatic stepCycle(input logic checkDataOut, input logic [31:0] expRead);
        @(negedge clk);
        if (checkDataOut) begin
            assert (dataOut === expRead) else begin
                $display("mismatch %s dataOut expected %h actual %h", curName, expRead, dataOut);
                errCount++;
            end
        end
        assert (bitReqs === mReq) else begin
            $display("mismatch %s bitReqs expected %b actual %b", curName, mReq, bitReqs);
            errCount++;
        end
        assert (sampleOut === mOut) else begin
            $display("mismatch %s sampleOut expected %0d actual %0d", curName, mOut, sampleOut);
            errCount++;
        end
        @(posedge clk);
        modelStep();
    endtask

    initial begin
        int unsigned seed;
        int          passCount;
        int          errBefore;
        seed = 77302;
        passCount = 0;
        void'($urandom(seed));
        rstN = 1'b0;
        cs = 1'b0;
        wrEn = 1'b0;
        byteEn = '0;
        addr = '0;
        dataIn = '0;
        symbolBits = '0;
        loadCases();
        modelStep();
        repeat (2) begin
            @(posedge clk);
            modelStep();
        end
        rstN <= 1'b1;
        for (int k = 0; k < qKind.size(); k++) begin
            curName = qName[k];
            errBefore = errCount;
            if (qKind[k] == "W") begin
                driveBus(1'b1, 1'b1, qA[k], qB[k], qC[k]);
                stepCycle(1'b0, '0);
            end else if (qKind[k] == "R") begin
                driveBus(1'b1, 1'b0, qA[k], '0, '0);
                stepCycle(1'b1, qB[k]);
            end else begin
                // Chip select is low during runs so dataOut reads zero
                repeat (qA[k]) begin
                    driveBus(1'b0, 1'b0, '0, '0, '0);
                    stepCycle(1'b1, '0);
                end
            end
            if (errCount == errBefore) begin
                passCount++;
                $display("case %s ok", curName);
            end else begin
                failCount++;
                $display("case %s fail", curName);
            end
        end
        $display("cases passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/fmChannel.sv ====
`default_nettype none

module fmChannel
    import fmDspPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire chanCfgT cfg,
    input  wire logic    dataBit,
    output logic         bitReq,
    output sampleT       sample
);

    logic        toggleQ;
    logic        enable;
    logic [15:0] divCnt;
    logic        divHit;
    logic        symbolQ;
    logic [31:0] phaseQ;
    logic [31:0] devExt;
    logic [31:0] phaseStep;
    sampleT      phaseHi;

    // Half-rate mode advances on every second cycle
    assign enable = !cfg.modClkSel || toggleQ;

    assign divHit = divCnt >= cfg.bitrateDiv;

    assign devExt    = {{14{cfg.deviation[17]}}, cfg.deviation};
    assign phaseStep = symbolQ ? cfg.carrierFreq + devExt : cfg.carrierFreq - devExt;

    assign phaseHi = sampleT'(phaseQ[31:16]);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            toggleQ <= 1'b0;
        end else begin
            toggleQ <= cfg.modClkSel ? !toggleQ : 1'b0;
        end
    end

    // Bit-rate divider and symbol latch
    always_ff @(posedge clk) begin
        if (!rstN) begin
            divCnt  <= '0;
            bitReq  <= 1'b0;
            symbolQ <= 1'b0;
        end else begin
            bitReq <= 1'b0;
            if (enable) begin
                if (divHit) begin
                    divCnt  <= '0;
                    bitReq  <= 1'b1;
                    symbolQ <= dataBit;
                end else begin
                    divCnt <= divCnt + 16'd1;
                end
            end
        end
    end

    // NCO phase accumulator
    always_ff @(posedge clk) begin
        if (!rstN) begin
            phaseQ <= '0;
        end else if (enable) begin
            phaseQ <= phaseQ + phaseStep;
        end
    end

    // Sawtooth taken from the top phase bits
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sample <= '0;
        end else begin
            sample <= phaseHi >>> cfg.cicShift;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (bitReq && cfg.modClkSel) |=> !bitReq);

endmodule

`default_nettype wire

// ==== source/fmCombiner.sv ====
`default_nettype none

module fmCombiner
    import fmDspPkg::*;
#(
    parameter int numChannels = 4
) (
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire sampleT samples [numChannels],
    output sampleT      sampleOut
);

    // Enough headroom for the worst-case sum
    localparam int accWidth  = sampleWidth + $clog2(numChannels) + 1;
    localparam int sampleMax = 2 ** (sampleWidth - 1) - 1;
    localparam int sampleMin = -(2 ** (sampleWidth - 1));

    logic signed [accWidth-1:0] sumAll;
    sampleT                     satVal;

    always_comb begin
        sumAll = '0;
        for (int i = 0; i < numChannels; i++) begin
            sumAll = sumAll + samples[i];
        end
    end

    // Clamp to the signed sample range
    always_comb begin
        if (sumAll > sampleMax) begin
            satVal = sampleT'(sampleMax);
        end else if (sumAll < sampleMin) begin
            satVal = sampleT'(sampleMin);
        end else begin
            satVal = sampleT'(sumAll);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sampleOut <= '0;
        end else begin
            sampleOut <= satVal;
        end
    end

    // Any X from a channel would show up here
    assert property (@(posedge clk) rstN |=> !$isunknown(sampleOut));

endmodule

`default_nettype wire

// ==== source/fmDspPkg.sv ====
`default_nettype none

package fmDspPkg;

    localparam int sampleWidth = 16;

    typedef logic signed [sampleWidth-1:0] sampleT;

    // Settings of one modulator channel
    typedef struct packed {
        logic [31:0] carrierFreq;
        logic [17:0] deviation;
        logic [15:0] bitrateDiv;
        logic        modClkSel;
        logic [4:0]  cicShift;
    } chanCfgT;

endpackage

`default_nettype wire

// ==== source/fmModRegs.sv ====
`default_nettype none

module fmModRegs
    import fmRegPkg::*, fmDspPkg::*;
#(
    parameter int numChannels = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 cs,
    input  wire logic                 wrEn,
    input  wire logic [3:0]           byteEn,
    input  wire logic [addrWidth-1:0] addr,
    input  wire logic [31:0]          dataIn,
    output logic      [31:0]          dataOut,
    output chanCfgT                   chanCfg [numChannels]
);

    localparam int cfgBits = $bits(chanCfgT);

    logic [3:0]  chanSel;
    regOffsetT   offSel;
    logic        chanValid;
    logic        wrHit;
    bitrateWordU wrWord;
    bitrateWordU rdWord;
    chanCfgT     rdCfg;
    logic [numChannels*cfgBits-1:0] cfgFlat;

    assign chanSel   = addr[chanMsb:chanLsb];
    assign offSel    = regOffsetT'(addr[offMsb:offLsb]);
    assign chanValid = int'(chanSel) < numChannels;
    assign wrHit     = cs && wrEn && chanValid;
    assign wrWord    = bitrateWordU'(dataIn);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numChannels; i++) begin
                chanCfg[i] <= '0;
            end
        end else if (wrHit) begin
            for (int i = 0; i < numChannels; i++) begin
                if (chanSel == 4'(i)) begin
                    case (offSel)
                        offFreq: begin
                            if (byteEn[0]) chanCfg[i].carrierFreq[7:0]   <= dataIn[7:0];
                            if (byteEn[1]) chanCfg[i].carrierFreq[15:8]  <= dataIn[15:8];
                            if (byteEn[2]) chanCfg[i].carrierFreq[23:16] <= dataIn[23:16];
                            if (byteEn[3]) chanCfg[i].carrierFreq[31:24] <= dataIn[31:24];
                        end
                        offDev: begin
                            if (byteEn[0]) chanCfg[i].deviation[7:0]   <= dataIn[7:0];
                            if (byteEn[1]) chanCfg[i].deviation[15:8]  <= dataIn[15:8];
                            if (byteEn[2]) chanCfg[i].deviation[17:16] <= dataIn[17:16];
                        end
                        offBitrate: begin
                            if (byteEn[0]) begin
                                chanCfg[i].bitrateDiv[7:0] <= wrWord.fields.bitrateDiv[7:0];
                            end
                            if (byteEn[1]) begin
                                chanCfg[i].bitrateDiv[15:8] <= wrWord.fields.bitrateDiv[15:8];
                            end
                            // Lane 2 carries only unused bits here
                            if (byteEn[3]) chanCfg[i].modClkSel <= wrWord.fields.modClkSel;
                        end
                        offCic: begin
                            if (byteEn[0]) chanCfg[i].cicShift <= dataIn[4:0];
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // Readback mux
    always_comb begin
        rdCfg   = '0;
        rdWord  = '0;
        dataOut = '0;
        for (int i = 0; i < numChannels; i++) begin
            if (chanSel == 4'(i)) begin
                rdCfg = chanCfg[i];
            end
        end
        rdWord.fields.modClkSel  = rdCfg.modClkSel;
        rdWord.fields.bitrateDiv = rdCfg.bitrateDiv;
        if (cs && chanValid) begin
            case (offSel)
                offFreq:    dataOut = rdCfg.carrierFreq;
                offDev:     dataOut = {14'd0, rdCfg.deviation};
                offBitrate: dataOut = rdWord.raw;
                offCic:     dataOut = {27'd0, rdCfg.cicShift};
                default:    dataOut = '0;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < numChannels; i++) begin
            cfgFlat[i*cfgBits +: cfgBits] = chanCfg[i];
        end
    end

    // Out-of-range channel writes leave every bank untouched
    assert property (@(posedge clk) disable iff (!rstN)
        (cs && wrEn && !chanValid) |=> $stable(cfgFlat));

endmodule

`default_nettype wire

// ==== source/fmModTop.sv ====
`default_nettype none

module fmModTop
    import fmDspPkg::*;
#(
    parameter int numChannels = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   cs,
    input  wire logic                   wrEn,
    input  wire logic [3:0]             byteEn,
    input  wire logic [11:0]            addr,
    input  wire logic [31:0]            dataIn,
    output wire logic [31:0]            dataOut,
    input  wire logic [numChannels-1:0] symbolBits,
    output wire logic [numChannels-1:0] bitReqs,
    output wire sampleT                 sampleOut
);

    wire chanCfgT chanCfg [numChannels];
    wire sampleT  samples [numChannels];

    fmModRegs #(
        .numChannels(numChannels)
    ) i_fmModRegs (
        .clk,
        .rstN,
        .cs,
        .wrEn,
        .byteEn,
        .addr,
        .dataIn,
        .dataOut,
        .chanCfg
    );

    for (genvar i = 0; i < numChannels; i++) begin : gChan
        fmChannel i_fmChannel (
            .clk,
            .rstN,
            .cfg     (chanCfg[i]),
            .dataBit (symbolBits[i]),
            .bitReq  (bitReqs[i]),
            .sample  (samples[i])
        );
    end

    fmCombiner #(
        .numChannels(numChannels)
    ) i_fmCombiner (
        .clk,
        .rstN,
        .samples,
        .sampleOut
    );

endmodule

`default_nettype wire

// ==== source/fmRegPkg.sv ====
`default_nettype none

package fmRegPkg;

    // Bus address layout
    localparam int addrWidth = 12;
    localparam int chanMsb   = 11;
    localparam int chanLsb   = 8;
    localparam int offMsb    = 3;
    localparam int offLsb    = 0;

    // Register offset within one channel
    typedef enum logic [3:0] {
        offFreq    = 4'd0,
        offDev     = 4'd1,
        offBitrate = 4'd2,
        offCic     = 4'd3
    } regOffsetT;

    // Field view of the bit-rate register
    typedef struct packed {
        logic        modClkSel;
        logic [14:0] unused;
        logic [15:0] bitrateDiv;
    } bitrateFieldsT;

    // Same word seen as raw bus data or as fields
    typedef union packed {
        logic [31:0]   raw;
        bitrateFieldsT fields;
    } bitrateWordU;

endpackage

`default_nettype wire

// ==== src.f ====
source/fmRegPkg.sv
source/fmDspPkg.sv
source/fmModRegs.sv
source/fmChannel.sv
source/fmCombiner.sv
source/fmModTop.sv
sim/fmModTb.sv
